/* hw/mips_pkg.sv */
package mips_pkg;

	// datapath and register file geometry
	localparam int XLEN       = 32;
	localparam int REG_ADDR_W = 5;
	localparam int NUM_REGS   = 32;
	localparam int STRB_W     = XLEN / 8;
	localparam int PERF_W     = 32;

	// the all-zero word is the architectural nop
	localparam logic [XLEN-1:0] NOP_WORD = '0;

	// one state per step of the multi-cycle sequence
	typedef enum logic [3:0] {
		ST_RST,
		ST_IF,
		ST_IW,
		ST_ID,
		ST_EX,
		ST_LD,
		ST_ST,
		ST_RDW,
		ST_WB
	} state_e;

	// primary opcode field, bits 31:26
	typedef enum logic [5:0] {
		OP_SPECIAL = 6'b000000,
		OP_J       = 6'b000010,
		OP_BEQ     = 6'b000100,
		OP_BNE     = 6'b000101,
		OP_ADDIU   = 6'b001001,
		OP_ANDI    = 6'b001100,
		OP_ORI     = 6'b001101,
		OP_LUI     = 6'b001111,
		OP_LW      = 6'b100011,
		OP_SW      = 6'b101011
	} opcode_e;

	// function field of SPECIAL, bits 5:0
	typedef enum logic [5:0] {
		FN_ADDU = 6'b100001,
		FN_SUBU = 6'b100011,
		FN_AND  = 6'b100100,
		FN_OR   = 6'b100101,
		FN_SLT  = 6'b101010
	} funct_e;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_SLT
	} alu_op_e;

	// the FSM only cares about this grouping
	typedef enum logic [2:0] {
		CLS_ALU,
		CLS_LOAD,
		CLS_STORE,
		CLS_BRANCH,
		CLS_JUMP,
		CLS_NOP
	} inst_class_e;

	typedef enum logic [1:0] {
		WB_ALU,
		WB_MEM,
		WB_UPPER_IMM
	} wb_sel_e;

	typedef struct packed {
		inst_class_e           inst_class;
		alu_op_e               alu_op;
		// operand b from the immediate instead of rt
		logic                  imm_sel;
		// zero- rather than sign-extend the immediate
		logic                  zero_ext;
		wb_sel_e               wb_sel;
		logic [REG_ADDR_W-1:0] dest;
		logic                  reg_write;
		// invert the zero test, bne
		logic                  branch_ne;
	} ctrl_t;

	typedef struct packed {
		logic [XLEN-1:0]   addr;
		logic              read;
		logic              write;
		logic [XLEN-1:0]   wdata;
		logic [STRB_W-1:0] strb;
	} mem_req_t;

	typedef struct packed {
		logic                  wen;
		logic [REG_ADDR_W-1:0] waddr;
		logic [XLEN-1:0]       wdata;
		logic [XLEN-1:0]       pc;
	} retire_t;

	typedef struct packed {
		logic [PERF_W-1:0] cycles;
		logic [PERF_W-1:0] fetched;
		logic [PERF_W-1:0] mem_stall;
		logic [PERF_W-1:0] br_taken;
	} perf_t;

endpackage

/* hw/mips_fsm.sv */
`timescale 1ns/1ps

module mips_fsm import mips_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  inst_class_e inst_class,
	input  logic        inst_req_ready,
	input  logic        inst_valid,
	input  logic        mem_req_ready,
	input  logic        read_data_valid,
	output state_e      state,
	output logic        inst_req_valid,
	output logic        inst_ready,
	output logic        read_data_ready
);

	state_e next_state;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_RST;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			ST_RST: next_state = ST_IF;
			// wait for the fetch request to be taken
			ST_IF: if (inst_req_ready) next_state = ST_IW;
			// wait for the instruction word
			ST_IW: if (inst_valid) next_state = ST_ID;
			// a nop needs no execute step
			ST_ID: next_state = (inst_class == CLS_NOP) ? ST_IF : ST_EX;
			ST_EX: begin
				case (inst_class)
					CLS_ALU:   next_state = ST_WB;
					CLS_LOAD:  next_state = ST_LD;
					CLS_STORE: next_state = ST_ST;
					// branch, jump and anything left over refetch
					default:   next_state = ST_IF;
				endcase
			end
			ST_LD: if (mem_req_ready) next_state = ST_RDW;
			ST_ST: if (mem_req_ready) next_state = ST_IF;
			ST_RDW: if (read_data_valid) next_state = ST_WB;
			ST_WB: next_state = ST_IF;
			default: next_state = ST_RST;
		endcase
	end

	// handshake enables come straight from the state
	assign inst_req_valid  = (state == ST_IF);
	// also ready in RST so nothing left over from reset hangs the bus
	assign inst_ready      = (state == ST_RST) || (state == ST_IW);
	assign read_data_ready = (state == ST_RST) || (state == ST_RDW);

endmodule

/* hw/mips_decoder.sv */
`timescale 1ns/1ps

module mips_decoder import mips_pkg::*; (
	input  logic [XLEN-1:0] instr,
	output ctrl_t           ctrl
);

	opcode_e               opcode;
	funct_e                funct;
	logic [REG_ADDR_W-1:0] rt;
	logic [REG_ADDR_W-1:0] rd;

	// instruction fields
	assign opcode = opcode_e'(instr[31:26]);
	assign funct  = funct_e'(instr[5:0]);
	assign rt     = instr[20:16];
	assign rd     = instr[15:11];

	always_comb begin
		// defaults describe a nop writing nothing
		ctrl            = '0;
		ctrl.inst_class = CLS_NOP;
		ctrl.alu_op     = ALU_ADD;
		ctrl.wb_sel     = WB_ALU;
		ctrl.dest       = rt;
		if (instr != NOP_WORD) begin
			case (opcode)
				OP_SPECIAL: begin
					// register form writes rd
					ctrl.dest = rd;
					ctrl.inst_class = CLS_ALU;
					ctrl.reg_write = 1'b1;
					case (funct)
						FN_ADDU: ctrl.alu_op = ALU_ADD;
						FN_SUBU: ctrl.alu_op = ALU_SUB;
						FN_AND:  ctrl.alu_op = ALU_AND;
						FN_OR:   ctrl.alu_op = ALU_OR;
						FN_SLT:  ctrl.alu_op = ALU_SLT;
						default: begin
							// unknown function code
							ctrl.inst_class = CLS_NOP;
							ctrl.reg_write = 1'b0;
						end
					endcase
				end
				OP_J: ctrl.inst_class = CLS_JUMP;
				OP_BEQ, OP_BNE: begin
					// rs - rt, taken on the zero flag
					ctrl.inst_class = CLS_BRANCH;
					ctrl.alu_op = ALU_SUB;
					ctrl.branch_ne = (opcode == OP_BNE);
				end
				OP_ADDIU, OP_ANDI, OP_ORI, OP_LUI: begin
					ctrl.inst_class = CLS_ALU;
					ctrl.imm_sel = 1'b1;
					ctrl.reg_write = 1'b1;
					// logic immediates are zero-extended
					ctrl.zero_ext = (opcode == OP_ANDI) || (opcode == OP_ORI);
					if (opcode == OP_ANDI) ctrl.alu_op = ALU_AND;
					if (opcode == OP_ORI) ctrl.alu_op = ALU_OR;
					if (opcode == OP_LUI) ctrl.wb_sel = WB_UPPER_IMM;
				end
				OP_LW: begin
					// address is rs + offset
					ctrl.inst_class = CLS_LOAD;
					ctrl.imm_sel = 1'b1;
					ctrl.wb_sel = WB_MEM;
					ctrl.reg_write = 1'b1;
				end
				OP_SW: begin
					ctrl.inst_class = CLS_STORE;
					ctrl.imm_sel = 1'b1;
				end
				default: ctrl.inst_class = CLS_NOP;
			endcase
		end
	end

endmodule

/* hw/reg_file.sv */
`timescale 1ns/1ps

module reg_file import mips_pkg::*; (
	input  logic                  clk,
	input  logic [REG_ADDR_W-1:0] raddr1,
	input  logic [REG_ADDR_W-1:0] raddr2,
	output logic [XLEN-1:0]       rdata1,
	output logic [XLEN-1:0]       rdata2,
	input  logic                  wen,
	input  logic [REG_ADDR_W-1:0] waddr,
	input  logic [XLEN-1:0]       wdata
);

	logic [XLEN-1:0] regs [NUM_REGS];

	// single write port, r0 never stored
	always_ff @(posedge clk) begin
		if (wen && (waddr != '0)) begin
			regs[waddr] <= wdata;
		end
	end

	// asynchronous reads, r0 reads as zero
	assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

/* hw/mips_alu.sv */
`timescale 1ns/1ps

module mips_alu import mips_pkg::*; (
	input  logic [XLEN-1:0] a,
	input  logic [XLEN-1:0] b,
	input  alu_op_e         op,
	output logic [XLEN-1:0] result,
	output logic            zero
);

	always_comb begin
		case (op)
			ALU_ADD: result = a + b;
			ALU_SUB: result = a - b;
			ALU_AND: result = a & b;
			ALU_OR:  result = a | b;
			// signed compare, result is 0 or 1
			ALU_SLT: result = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
			default: result = '0;
		endcase
	end

	// beq and bne look only at this flag
	assign zero = (result == '0);

endmodule

/* hw/mips_datapath.sv */
`timescale 1ns/1ps

module mips_datapath import mips_pkg::*; (
	input  logic            clk,
	input  logic            rst,
	input  state_e          state,
	input  ctrl_t           ctrl,
	input  logic [XLEN-1:0] instruction,
	input  logic            inst_fire,
	input  logic [XLEN-1:0] read_data,
	input  logic            read_fire,
	output logic [XLEN-1:0] pc,
	output logic [XLEN-1:0] instr,
	output mem_req_t        mem_req,
	output retire_t         retire,
	output logic            branch_taken
);

	logic [XLEN-1:0] fetch_pc;
	logic [XLEN-1:0] op_a;
	logic [XLEN-1:0] op_b;
	logic [XLEN-1:0] result_q;
	logic [XLEN-1:0] rdata_q;
	logic [XLEN-1:0] rf_rdata1;
	logic [XLEN-1:0] rf_rdata2;
	logic [XLEN-1:0] imm_ext;
	logic [XLEN-1:0] alu_b;
	logic [XLEN-1:0] alu_result;
	logic            alu_zero;
	logic [XLEN-1:0] pc_plus4;
	logic [XLEN-1:0] br_target;
	logic [XLEN-1:0] j_target;
	logic [XLEN-1:0] wb_value;
	logic            rf_wen;
	logic [15:0]     imm;

	assign imm = instr[15:0];
	assign imm_ext = ctrl.zero_ext ? {16'b0, imm} : {{16{imm[15]}}, imm};

	// dedicated adders, the ALU is left to the instruction
	assign pc_plus4 = pc + 32'd4;
	// pc already holds PC+4 once decode starts
	assign br_target = pc + {{14{imm[15]}}, imm, 2'b00};
	assign j_target = {pc[31:28], instr[25:0], 2'b00};

	// taken when equal for beq, when not equal for bne
	assign branch_taken = (state == ST_EX) && (ctrl.inst_class == CLS_BRANCH) &&
		(alu_zero ^ ctrl.branch_ne);

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= '0;
		end else if ((state == ST_IW) && inst_fire) begin
			pc <= pc_plus4;
		end else if (branch_taken) begin
			pc <= br_target;
		end else if ((state == ST_EX) && (ctrl.inst_class == CLS_JUMP)) begin
			pc <= j_target;
		end
	end

	// instruction word and its address, kept for decode and retire
	always_ff @(posedge clk) begin
		if ((state == ST_IW) && inst_fire) begin
			instr <= instruction;
			fetch_pc <= pc;
		end
	end

	// operands sampled in ID, held through EX and the memory steps
	always_ff @(posedge clk) begin
		if (state == ST_ID) begin
			op_a <= rf_rdata1;
			op_b <= rf_rdata2;
		end
	end

	// lui bypasses the ALU, its value is ready at once
	always_ff @(posedge clk) begin
		if (state == ST_EX) begin
			result_q <= (ctrl.wb_sel == WB_UPPER_IMM) ? {imm, 16'b0} : alu_result;
		end
	end

	always_ff @(posedge clk) begin
		if (read_fire) begin
			rdata_q <= read_data;
		end
	end

	assign alu_b = ctrl.imm_sel ? imm_ext : op_b;

	mips_alu alu_i (
		.a      (op_a),
		.b      (alu_b),
		.op     (ctrl.alu_op),
		.result (alu_result),
		.zero   (alu_zero)
	);

	// write-back source, r0 reports zero like the register itself
	assign wb_value = (ctrl.dest == '0) ? '0 :
		(ctrl.wb_sel == WB_MEM) ? rdata_q : result_q;
	assign rf_wen = (state == ST_WB) && ctrl.reg_write;

	reg_file reg_file_i (
		.clk    (clk),
		.raddr1 (instr[25:21]),
		.raddr2 (instr[20:16]),
		.rdata1 (rf_rdata1),
		.rdata2 (rf_rdata2),
		.wen    (rf_wen),
		.waddr  (ctrl.dest),
		.wdata  (wb_value)
	);

	// word accesses only, low address bits dropped
	assign mem_req.addr = {result_q[XLEN-1:2], 2'b00};
	assign mem_req.read = (state == ST_LD);
	assign mem_req.write = (state == ST_ST);
	assign mem_req.wdata = op_b;
	assign mem_req.strb = '1;

	assign retire.wen = rf_wen;
	assign retire.waddr = ctrl.dest;
	assign retire.wdata = wb_value;
	assign retire.pc = fetch_pc;

endmodule

/* hw/perf_counters.sv */
`timescale 1ns/1ps

module perf_counters import mips_pkg::*; (
	input  logic   clk,
	input  logic   rst,
	input  state_e state,
	input  logic   inst_req_ready,
	input  logic   mem_req_ready,
	input  logic   read_data_valid,
	input  logic   branch_taken,
	output perf_t  perf
);

	logic fetch_ev;
	logic stall_ev;

	// fetch request accepted this cycle
	assign fetch_ev = (state == ST_IF) && inst_req_ready;

	// request held without ready, or waiting on read data
	assign stall_ev = (((state == ST_LD) || (state == ST_ST)) && !mem_req_ready) ||
		((state == ST_RDW) && !read_data_valid);

	always_ff @(posedge clk) begin
		if (rst) begin
			perf <= '0;
		end else begin
			perf.cycles <= perf.cycles + 1'b1;
			if (fetch_ev) begin
				perf.fetched <= perf.fetched + 1'b1;
			end
			if (stall_ev) begin
				perf.mem_stall <= perf.mem_stall + 1'b1;
			end
			if (branch_taken) begin
				perf.br_taken <= perf.br_taken + 1'b1;
			end
		end
	end

endmodule

/* hw/mips_core.sv */
`timescale 1ns/1ps

module mips_core import mips_pkg::*; (
	input  logic            clk,
	input  logic            rst,
	// fetch request
	output logic [XLEN-1:0] pc,
	output logic            inst_req_valid,
	input  logic            inst_req_ready,
	// fetch response
	input  logic [XLEN-1:0] instruction,
	input  logic            inst_valid,
	output logic            inst_ready,
	// data request
	output mem_req_t        mem_req,
	input  logic            mem_req_ready,
	// read response
	input  logic [XLEN-1:0] read_data,
	input  logic            read_data_valid,
	output logic            read_data_ready,
	output retire_t         retire,
	output perf_t           perf
);

	state_e          state;
	ctrl_t           ctrl;
	logic [XLEN-1:0] instr;
	logic            inst_fire;
	logic            read_fire;
	logic            branch_taken;

	// a transfer happens when both sides agree
	assign inst_fire = inst_ready && inst_valid;
	assign read_fire = read_data_ready && read_data_valid;

	mips_fsm fsm_i (
		.clk             (clk),
		.rst             (rst),
		.inst_class      (ctrl.inst_class),
		.inst_req_ready  (inst_req_ready),
		.inst_valid      (inst_valid),
		.mem_req_ready   (mem_req_ready),
		.read_data_valid (read_data_valid),
		.state           (state),
		.inst_req_valid  (inst_req_valid),
		.inst_ready      (inst_ready),
		.read_data_ready (read_data_ready)
	);

	mips_decoder decoder_i (
		.instr (instr),
		.ctrl  (ctrl)
	);

	mips_datapath datapath_i (
		.clk          (clk),
		.rst          (rst),
		.state        (state),
		.ctrl         (ctrl),
		.instruction  (instruction),
		.inst_fire    (inst_fire),
		.read_data    (read_data),
		.read_fire    (read_fire),
		.pc           (pc),
		.instr        (instr),
		.mem_req      (mem_req),
		.retire       (retire),
		.branch_taken (branch_taken)
	);

	perf_counters perf_i (
		.clk             (clk),
		.rst             (rst),
		.state           (state),
		.inst_req_ready  (inst_req_ready),
		.mem_req_ready   (mem_req_ready),
		.read_data_valid (read_data_valid),
		.branch_taken    (branch_taken),
		.perf            (perf)
	);

endmodule

/* verification/mips_core_props.sv */
`timescale 1ns/1ps

module mips_core_props import mips_pkg::*; (
	input logic            clk,
	input logic            rst,
	input logic [XLEN-1:0] pc,
	input logic            inst_req_valid,
	input logic            inst_req_ready,
	input mem_req_t        mem_req,
	input retire_t         retire
);

	// a waiting fetch request keeps its address
	a_fetch_hold: assert property (@(posedge clk) disable iff (rst)
		inst_req_valid && !inst_req_ready |=> inst_req_valid && $stable(pc))
		else $error("fetch request changed before it was accepted");

	a_rw_exclusive: assert property (@(posedge clk) disable iff (rst)
		!(mem_req.read && mem_req.write))
		else $error("read and write requested together");

	// word accesses only
	a_aligned: assert property (@(posedge clk) disable iff (rst)
		(mem_req.read || mem_req.write) |-> (mem_req.addr[1:0] == 2'b00))
		else $error("data address not word aligned");

	a_full_strb: assert property (@(posedge clk) disable iff (rst)
		mem_req.write |-> (mem_req.strb == '1))
		else $error("store strobe not all ones");

	a_retire_pulse: assert property (@(posedge clk) disable iff (rst)
		retire.wen |=> !retire.wen)
		else $error("retire write lasted two cycles");

endmodule

bind mips_core mips_core_props props_i (
	.clk            (clk),
	.rst            (rst),
	.pc             (pc),
	.inst_req_valid (inst_req_valid),
	.inst_req_ready (inst_req_ready),
	.mem_req        (mem_req),
	.retire         (retire)
);

/* verification/mips_core_tb.sv */
`timescale 1ns/1ps

module mips_core_tb import mips_pkg::*; ();

	localparam int MAX_STALL = 2;

	logic            clk;
	logic            rst;
	logic [XLEN-1:0] pc;
	logic            inst_req_valid;
	logic            inst_req_ready;
	logic [XLEN-1:0] instruction;
	logic            inst_valid;
	logic            inst_ready;
	mem_req_t        mem_req;
	logic            mem_req_ready;
	logic [XLEN-1:0] read_data;
	logic            read_data_valid;
	logic            read_data_ready;
	retire_t         retire;
	perf_t           perf;

	// program and data storage plus the reference copies
	logic [31:0] imem [64];
	logic [31:0] dmem [256];
	logic [31:0] mdmem [256];
	logic [31:0] mregs [32];
	logic [31:0] halt_pc;

	// {waddr, wdata, pc} per register write
	logic [68:0] exp_ret[$];
	logic [68:0] got_ret[$];
	logic [31:0] exp_fetch[$];
	logic [31:0] got_fetch[$];
	// {addr, data} per store in program order
	logic [63:0] exp_store[$];

	int          errors;
	int          checks;
	int          tests;
	int          exp_taken;
	int          exp_steps;
	int          stall_cnt;
	int          cycles;
	int          limit;
	int unsigned seed;
	bit          stall_on;
	bit          halted;

	// bus model state
	bit          ifetch_pend;
	bit          ivalid_fired;
	bit          rd_pend;
	bit          rvalid_fired;
	int          iwait;
	int          rwait;
	int          freq_wait;
	int          dreq_wait;
	logic [31:0] iword;
	logic [31:0] rword;

	mips_core mips_core_i (
		.clk             (clk),
		.rst             (rst),
		.pc              (pc),
		.inst_req_valid  (inst_req_valid),
		.inst_req_ready  (inst_req_ready),
		.instruction     (instruction),
		.inst_valid      (inst_valid),
		.inst_ready      (inst_ready),
		.mem_req         (mem_req),
		.mem_req_ready   (mem_req_ready),
		.read_data       (read_data),
		.read_data_valid (read_data_valid),
		.read_data_ready (read_data_ready),
		.retire          (retire),
		.perf            (perf)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// instruction encoders
	function automatic logic [31:0] enc_r(int rs, int rt, int rd, funct_e fn);
		return {6'b000000, 5'(rs), 5'(rt), 5'(rd), 5'b00000, fn};
	endfunction

	function automatic logic [31:0] enc_i(opcode_e op, int rs, int rt, logic [15:0] imm);
		return {op, 5'(rs), 5'(rt), imm};
	endfunction

	function automatic logic [31:0] enc_j(int word_addr);
		return {OP_J, 26'(word_addr)};
	endfunction

	function automatic int pick_delay();
		return stall_on ? int'($urandom_range(MAX_STALL, 0)) : 0;
	endfunction

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] got);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch at %0t: %s expected %h got %h", $time, name, exp, got);
		end
	endtask

	// reference model register write where r0 reports zero
	task automatic model_write(input logic [4:0] rd, input logic [31:0] val,
			input logic [31:0] ipc);
		exp_ret.push_back({rd, (rd == 5'd0) ? 32'd0 : val, ipc});
		if (rd != 5'd0) mregs[rd] = val;
	endtask

	// executes the loaded program up to the halt address
	task automatic model_run();
		logic [31:0] mpc;
		logic [31:0] ins;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] sx;
		logic [31:0] zx;
		logic [31:0] ea;
		logic [31:0] npc;
		exp_ret.delete();
		exp_fetch.delete();
		exp_store.delete();
		exp_taken = 0;
		exp_steps = 0;
		for (int i = 0; i < 32; i++) mregs[i] = '0;
		mpc = '0;
		while ((mpc != halt_pc) && (exp_steps < 1000)) begin
			ins = imem[mpc[7:2]];
			exp_fetch.push_back(mpc);
			exp_steps++;
			a = mregs[ins[25:21]];
			b = mregs[ins[20:16]];
			sx = {{16{ins[15]}}, ins[15:0]};
			zx = {16'b0, ins[15:0]};
			ea = a + sx;
			npc = mpc + 32'd4;
			case (ins[31:26])
				OP_SPECIAL: begin
					case (ins[5:0])
						FN_ADDU: model_write(ins[15:11], a + b, mpc);
						FN_SUBU: model_write(ins[15:11], a - b, mpc);
						FN_AND:  model_write(ins[15:11], a & b, mpc);
						FN_OR:   model_write(ins[15:11], a | b, mpc);
						FN_SLT:  model_write(ins[15:11], ($signed(a) < $signed(b)) ? 1 : 0, mpc);
						default: ;
					endcase
				end
				OP_ADDIU: model_write(ins[20:16], ea, mpc);
				OP_ANDI:  model_write(ins[20:16], a & zx, mpc);
				OP_ORI:   model_write(ins[20:16], a | zx, mpc);
				OP_LUI:   model_write(ins[20:16], {ins[15:0], 16'b0}, mpc);
				OP_LW:    model_write(ins[20:16], mdmem[ea[9:2]], mpc);
				OP_SW: begin
					exp_store.push_back({ea & ~32'd3, b});
					mdmem[ea[9:2]] = b;
				end
				OP_BEQ, OP_BNE: begin
					if ((a == b) == (ins[31:26] == OP_BEQ)) begin
						npc = npc + {sx[29:0], 2'b00};
						exp_taken++;
					end
				end
				OP_J: npc = {npc[31:28], ins[25:0], 2'b00};
				default: ;
			endcase
			mpc = npc;
		end
	endtask

	// an accepted data request is either a store or the start of a read
	task automatic serve_request();
		logic [63:0] st;
		if (mem_req.write) begin
			check("mem_req.strb", 32'hf, 32'(mem_req.strb));
			if (exp_store.size() == 0) begin
				errors++;
				$display("unexpected store request to address %h", mem_req.addr);
			end else begin
				st = exp_store.pop_front();
				check("mem_req.addr", st[63:32], mem_req.addr);
				check("mem_req.wdata", st[31:0], mem_req.wdata);
			end
			dmem[mem_req.addr[9:2]] = mem_req.wdata;
		end else begin
			rd_pend = 1'b1;
			rword = dmem[mem_req.addr[9:2]];
			rwait = pick_delay();
		end
	endtask

	// one clock of the memory models with everything decided at the falling edge
	task automatic cycle_step();
		@(negedge clk);
		cycles++;
		if (cycles > limit) begin
			$display("timeout after %0d cycles, program never reached its halt address", cycles);
			$display("ERRORS FOUND");
			$finish;
		end else begin
			if (retire.wen) got_ret.push_back({retire.waddr, retire.wdata, retire.pc});
			// instruction response held until taken
			if (ivalid_fired) begin
				inst_valid = 1'b0;
				ivalid_fired = 1'b0;
			end
			if (ifetch_pend && !inst_valid) begin
				if (iwait == 0) begin
					inst_valid = 1'b1;
					instruction = iword;
				end else begin
					iwait--;
				end
			end
			if (inst_valid && inst_ready) begin
				ivalid_fired = 1'b1;
				ifetch_pend = 1'b0;
			end
			// fetch request that is never accepted at the halt address
			inst_req_ready = 1'b0;
			if (inst_req_valid && !halted) begin
				if (pc == halt_pc) begin
					halted = 1'b1;
				end else if (freq_wait > 0) begin
					freq_wait--;
				end else begin
					inst_req_ready = 1'b1;
					got_fetch.push_back(pc);
					ifetch_pend = 1'b1;
					iword = imem[pc[7:2]];
					iwait = pick_delay();
					freq_wait = pick_delay();
				end
			end
			// read response
			if (rvalid_fired) begin
				read_data_valid = 1'b0;
				rvalid_fired = 1'b0;
			end
			if (rd_pend && !read_data_valid) begin
				if (rwait == 0) begin
					read_data_valid = 1'b1;
					read_data = rword;
				end else begin
					rwait--;
				end
			end
			if (read_data_ready && rd_pend && !read_data_valid) stall_cnt++;
			if (read_data_valid && read_data_ready) begin
				rvalid_fired = 1'b1;
				rd_pend = 1'b0;
			end
			// data request
			mem_req_ready = 1'b0;
			if (mem_req.read || mem_req.write) begin
				if (dreq_wait > 0) begin
					dreq_wait--;
					stall_cnt++;
				end else begin
					mem_req_ready = 1'b1;
					dreq_wait = pick_delay();
					serve_request();
				end
			end
		end
	endtask

	task automatic reset_core();
		rst = 1'b1;
		inst_req_ready = 1'b0;
		inst_valid = 1'b0;
		instruction = '0;
		mem_req_ready = 1'b0;
		read_data = '0;
		read_data_valid = 1'b0;
		ifetch_pend = 1'b0;
		ivalid_fired = 1'b0;
		rd_pend = 1'b0;
		rvalid_fired = 1'b0;
		freq_wait = pick_delay();
		dreq_wait = pick_delay();
		repeat (3) @(negedge clk);
		check("pc", 32'd0, pc);
		check("retire.wen", 32'd0, 32'(retire.wen));
		check("mem_req.read", 32'd0, 32'(mem_req.read));
		check("mem_req.write", 32'd0, 32'(mem_req.write));
		check("perf.cycles", 32'd0, perf.cycles);
		check("perf.fetched", 32'd0, perf.fetched);
		check("perf.mem_stall", 32'd0, perf.mem_stall);
		check("perf.br_taken", 32'd0, perf.br_taken);
		rst = 1'b0;
		cycles = 0;
		stall_cnt = 0;
		halted = 1'b0;
		got_ret.delete();
		got_fetch.delete();
	endtask

	// address-dependent fill so a wrong index shows up
	task automatic fill_memories();
		for (int i = 0; i < 256; i++) begin
			dmem[i] = 32'hc0de0000 ^ (i * 32'h9e3779b9);
			mdmem[i] = dmem[i];
		end
	endtask

	task automatic clear_program();
		for (int i = 0; i < 64; i++) imem[i] = enc_j(i);
	endtask

	task automatic run_program(input string name, input bit stalls);
		int e0;
		e0 = errors;
		stall_on = stalls;
		fill_memories();
		model_run();
		limit = exp_steps * (5 + 4 * MAX_STALL) + 20;
		reset_core();
		while (!halted) cycle_step();
		cycle_step();
		check("retire count", 32'(exp_ret.size()), 32'(got_ret.size()));
		for (int i = 0; (i < exp_ret.size()) && (i < got_ret.size()); i++) begin
			check("retire.waddr", 32'(exp_ret[i][68:64]), 32'(got_ret[i][68:64]));
			check("retire.wdata", exp_ret[i][63:32], got_ret[i][63:32]);
			check("retire.pc", exp_ret[i][31:0], got_ret[i][31:0]);
		end
		check("fetch count", 32'(exp_fetch.size()), 32'(got_fetch.size()));
		for (int i = 0; (i < exp_fetch.size()) && (i < got_fetch.size()); i++) begin
			check("fetch pc", exp_fetch[i], got_fetch[i]);
		end
		// one count per clock since reset was released
		check("perf.cycles", 32'(cycles), perf.cycles);
		check("perf.fetched", 32'(got_fetch.size()), perf.fetched);
		check("perf.br_taken", 32'(exp_taken), perf.br_taken);
		check("perf.mem_stall", 32'(stall_cnt), perf.mem_stall);
		check("stores left over", 32'd0, 32'(exp_store.size()));
		for (int i = 0; i < 256; i++) check("dmem", mdmem[i], dmem[i]);
		tests++;
		$display("test %s finished with %0d errors", name, errors - e0);
	endtask

	task automatic test_reset();
		int e0;
		e0 = errors;
		clear_program();
		halt_pc = 32'd0;
		stall_on = 1'b0;
		reset_core();
		// first cycle out of reset requests address 0
		@(negedge clk);
		check("inst_req_valid", 32'd1, 32'(inst_req_valid));
		check("pc", 32'd0, pc);
		tests++;
		$display("test reset finished with %0d errors", errors - e0);
	endtask

	task automatic test_alu();
		clear_program();
		imem[0] = enc_i(OP_ADDIU, 0, 1, 16'd5);
		imem[1] = enc_i(OP_ADDIU, 0, 2, 16'hfffd);
		imem[2] = enc_r(1, 2, 3, FN_ADDU);
		imem[3] = enc_r(2, 1, 4, FN_SUBU);
		imem[4] = enc_r(1, 2, 5, FN_AND);
		imem[5] = enc_r(1, 2, 6, FN_OR);
		imem[6] = enc_r(2, 1, 7, FN_SLT);
		imem[7] = enc_r(1, 2, 8, FN_SLT);
		imem[8] = enc_i(OP_ANDI, 2, 9, 16'hf0f0);
		imem[9] = enc_i(OP_ORI, 1, 10, 16'h8000);
		imem[10] = enc_i(OP_LUI, 0, 11, 16'h1234);
		// writes to r0 must report zero
		imem[11] = enc_r(1, 1, 0, FN_ADDU);
		imem[12] = enc_i(OP_ADDIU, 1, 0, 16'd7);
		imem[13] = enc_i(OP_LUI, 0, 0, 16'hffff);
		imem[14] = enc_r(0, 11, 12, FN_ADDU);
		halt_pc = 32'd15 * 4;
		run_program("alu_imm", 1'b0);
	endtask

	task automatic load_mem_program();
		clear_program();
		imem[0] = enc_i(OP_ADDIU, 0, 1, 16'h0040);
		imem[1] = enc_i(OP_ADDIU, 0, 2, 16'h1234);
		imem[2] = enc_i(OP_LUI, 0, 3, 16'hdead);
		imem[3] = enc_i(OP_ORI, 3, 3, 16'hbeef);
		imem[4] = enc_i(OP_SW, 1, 2, 16'h0000);
		imem[5] = enc_i(OP_SW, 1, 3, 16'h0008);
		imem[6] = enc_i(OP_SW, 1, 3, 16'hfffc);
		imem[7] = enc_i(OP_LW, 1, 4, 16'h0000);
		imem[8] = enc_i(OP_LW, 1, 5, 16'h0008);
		// untouched word that comes from the fill
		imem[9] = enc_i(OP_LW, 0, 6, 16'h0020);
		imem[10] = enc_r(4, 5, 7, FN_ADDU);
		imem[11] = enc_i(OP_SW, 1, 7, 16'h0010);
		imem[12] = enc_i(OP_LW, 1, 8, 16'h0010);
		halt_pc = 32'd13 * 4;
	endtask

	task automatic test_load_store();
		load_mem_program();
		run_program("load_store", 1'b0);
	endtask

	task automatic test_branch();
		clear_program();
		imem[0] = enc_i(OP_ADDIU, 0, 1, 16'd1);
		imem[1] = enc_i(OP_ADDIU, 0, 2, 16'd1);
		imem[2] = enc_i(OP_BEQ, 1, 2, 16'd2);
		imem[3] = enc_i(OP_ADDIU, 0, 3, 16'h0011);
		imem[4] = enc_i(OP_ADDIU, 0, 3, 16'h0022);
		imem[5] = enc_i(OP_BNE, 1, 2, 16'd1);
		imem[6] = NOP_WORD;
		imem[7] = enc_i(OP_BNE, 1, 0, 16'd1);
		imem[8] = enc_i(OP_ADDIU, 0, 4, 16'h0033);
		imem[9] = enc_i(OP_BEQ, 1, 0, 16'd1);
		imem[10] = enc_i(OP_ADDIU, 0, 4, 16'h0044);
		imem[11] = enc_j(13);
		imem[12] = enc_i(OP_ADDIU, 0, 5, 16'h0055);
		imem[13] = NOP_WORD;
		halt_pc = 32'd14 * 4;
		run_program("control_flow", 1'b0);
	endtask

	// same memory program with random back-pressure everywhere
	task automatic test_back_pressure();
		load_mem_program();
		run_program("back_pressure", 1'b1);
	endtask

	initial begin
		seed = $urandom(79348);
		errors = 0;
		checks = 0;
		tests = 0;
		stall_on = 1'b0;
		halt_pc = '0;
		test_reset();
		test_alu();
		test_load_store();
		test_branch();
		test_back_pressure();
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

/* vlog.f */
hw/mips_pkg.sv
hw/mips_fsm.sv
hw/mips_decoder.sv
hw/reg_file.sv
hw/mips_alu.sv
hw/mips_datapath.sv
hw/perf_counters.sv
hw/mips_core.sv
verification/mips_core_props.sv
verification/mips_core_tb.sv

/* run.sh */
#!/bin/sh
# build and run with Verilator, pass only if the log holds the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module mips_core_tb -o mips_sim &&
./obj_dir/mips_sim > sim.log 2>&1 ;
cat sim.log &&
grep -qx "NO ERRORS" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
